// File: ifm_out_fsm.sv
`timescale 1ns/10ps

module ifm_out_fsm (
   input  logic                        s2mm_clk,
   input  logic                        s2mm_resetn,

   // data fifo read side
   input  logic [ifm_pkg::beat_w-1:0]  data_rdata,
   output logic                        data_rden,

   // info fifo read side
   input  logic                        info_rdata,
   input  logic                        info_empty,
   output logic                        info_rden,

   // good fifo write side
   output logic [ifm_pkg::beat_w-1:0]  good_wdata,
   output logic                        good_wren,
   input  logic                        good_afull,

   // control fifo write side, data comes from the status gen
   output logic                        ctrl_wren,
   input  logic                        ctrl_afull,

   // status gen control
   output logic                        frame_clr,
   output logic                        beat_wr,
   output logic [ifm_pkg::keep_w-1:0]  beat_keep,
   output logic [2:0]                  word_idx
);

   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_copy   = 3'd1;
   localparam logic [2:0] st_drop   = 3'd2;
   localparam logic [2:0] st_status = 3'd3;
   localparam logic [2:0] st_done   = 3'd4;

   logic [2:0] state;
   logic [2:0] state_nxt;
   logic       start;
   logic       head_last;
   logic       copy_beat;
   logic       last_word;

   // verdict ready and room for a whole frame downstream
   assign start     = !info_empty && !good_afull && !ctrl_afull;
   assign head_last = data_rdata[ifm_pkg::beat_last];
   assign last_word = (word_idx == 3'(ifm_pkg::status_words - 1));

   // first beat popped already in idle
   assign data_rden = (state == st_idle && start) || state == st_copy || state == st_drop;

   // verdict retired together with the frame's last beat
   assign info_rden = data_rden && head_last;

   assign copy_beat = (state == st_idle && start && info_rdata) || state == st_copy;

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:
            if (start)
            begin
               // single beat frames skip copy / drop
               if (head_last)
                  state_nxt = info_rdata ? st_status : st_done;
               else
                  state_nxt = info_rdata ? st_copy : st_drop;
            end
         st_copy:
            if (head_last)
               state_nxt = st_status;
         st_drop:
            if (head_last)
               state_nxt = st_done;
         st_status:
            if (last_word)
               state_nxt = st_done;
         default:
            state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         state     <= st_idle;
         word_idx  <= '0;
         good_wren <= 1'b0;
         ctrl_wren <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         // counts 0..5 while in status, parked at 0 otherwise
         word_idx  <= (state == st_status) ? word_idx + 1'b1 : 3'd0;
         good_wren <= copy_beat;
         // lines up with the registered status word
         ctrl_wren <= (state == st_status);
      end
   end

   // head word registered on the same edge as the write enable
   always_ff @(posedge s2mm_clk)
   begin
      good_wdata <= data_rdata;
   end

   // byte count taken from what actually lands in the good fifo
   assign beat_wr   = good_wren;
   assign beat_keep = good_wdata[ifm_pkg::beat_keep_lsb +: ifm_pkg::keep_w];

   // counter held clear between frames
   assign frame_clr = (state == st_idle);

endmodule

// File: ifm_pkg.sv
package ifm_pkg;

   // mac side beat payload and byte enables
   localparam int data_w = 64;
   localparam int keep_w = 8;

   // data fifo word: {last, keep[7:0], data[63:0]}
   localparam int beat_w = data_w + keep_w + 1;
   localparam int beat_last = beat_w - 1;
   localparam int beat_keep_lsb = data_w;

   // control fifo word: {last, be[3:0], payload[31:0]}
   localparam int ctrl_w = 37;
   localparam int ctrl_last = ctrl_w - 1;

   // status words emitted per good frame
   localparam int status_words = 6;

   // word 0 flags, fixed pattern 5 in the top nibble
   localparam logic [31:0] stat_flags_word = 32'h5000_0000;

   // single flag bit set in word 3
   localparam int stat_word3_bit = 6;

   // frame byte counter, reported in word 5
   localparam int bytecnt_w = 16;

   // fifo geometry defaults used by the top level
   localparam int def_fifo_depth_log2 = 9;

   // must cover one max size frame (188 beats) plus pipeline slack
   localparam int def_afull_margin = 200;

endpackage

// File: ifm_rx.f
ifm_pkg.sv
ifm_sync_fifo.sv
ifm_rx_writer.sv
ifm_status_gen.sv
ifm_out_fsm.sv
ifm_rx_top.sv
tb_ifm_rx_assertions.sv
tb_ifm_rx.sv

// File: ifm_rx_cases.txt
# columns: verdict (1 good, 0 bad), frame length in bytes (decimal), data seed offset (hex)
# first line is the single byte frame right after reset
1 1 0
1 64 1
0 100 2
1 1500 3
1 1500 4
0 1500 5
1 1500 6
1 1500 7
1 1499 8
1 1497 9
0 60 a
1 9 b
1 1500 c
1 1500 d
1 777 e
0 1500 f
1 1500 10
1 3 11
1 1234 12
1 1500 13
0 1 14

// File: ifm_rx_top.sv
`timescale 1ns/10ps

module ifm_rx_top #(
   parameter int fifo_depth_log2 = ifm_pkg::def_fifo_depth_log2,
   parameter int afull_margin = ifm_pkg::def_afull_margin
) (
   input  logic                        s2mm_clk,
   input  logic                        s2mm_resetn,

   // mac stream in
   input  logic                        rx_valid,
   input  logic [ifm_pkg::data_w-1:0]  rx_data,
   input  logic [ifm_pkg::keep_w-1:0]  rx_keep,
   input  logic                        rx_last,
   input  logic                        rx_good,
   output logic                        rx_ready,

   // good frame fifo read port
   input  logic                        good_rden,
   output logic [ifm_pkg::beat_w-1:0]  good_rdata,
   output logic                        good_empty,

   // status word fifo read port
   input  logic                        ctrl_rden,
   output logic [ifm_pkg::ctrl_w-1:0]  ctrl_rdata,
   output logic                        ctrl_empty
);

   // writer to data / info fifos
   logic                       data_wren;
   logic [ifm_pkg::beat_w-1:0] data_wdata;
   logic                       data_full;
   logic                       info_wren;
   logic                       info_wdata;
   logic                       info_full;

   // fifos to fsm
   logic [ifm_pkg::beat_w-1:0] data_rdata;
   logic                       data_rden;
   logic                       info_rdata;
   logic                       info_empty;
   logic                       info_rden;

   // fsm to output fifos
   logic [ifm_pkg::beat_w-1:0] good_wdata;
   logic                       good_wren;
   logic                       good_afull;
   logic [ifm_pkg::ctrl_w-1:0] ctrl_wdata;
   logic                       ctrl_wren;
   logic                       ctrl_afull;

   // fsm to status gen
   logic                       frame_clr;
   logic                       beat_wr;
   logic [ifm_pkg::keep_w-1:0] beat_keep;
   logic [2:0]                 word_idx;

   ifm_rx_writer i_rx_writer (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .rx_keep     (rx_keep),
      .rx_last     (rx_last),
      .rx_good     (rx_good),
      .rx_ready    (rx_ready),
      .data_wren   (data_wren),
      .data_wdata  (data_wdata),
      .data_full   (data_full),
      .info_wren   (info_wren),
      .info_wdata  (info_wdata),
      .info_full   (info_full)
   );

   // frame buffer, drained whenever the fsm has a verdict
   ifm_sync_fifo #(
      .width        (ifm_pkg::beat_w),
      .depth_log2   (fifo_depth_log2),
      .afull_margin (afull_margin)
   ) i_data_fifo (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .wren        (data_wren),
      .wdata       (data_wdata),
      .rden        (data_rden),
      .rdata       (data_rdata),
      .empty       (),
      .full        (data_full),
      .afull       ()
   );

   // one good / bad bit per stored frame
   ifm_sync_fifo #(
      .width        (1),
      .depth_log2   (fifo_depth_log2),
      .afull_margin (afull_margin)
   ) i_info_fifo (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .wren        (info_wren),
      .wdata       (info_wdata),
      .rden        (info_rden),
      .rdata       (info_rdata),
      .empty       (info_empty),
      .full        (info_full),
      .afull       ()
   );

   ifm_sync_fifo #(
      .width        (ifm_pkg::beat_w),
      .depth_log2   (fifo_depth_log2),
      .afull_margin (afull_margin)
   ) i_good_fifo (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .wren        (good_wren),
      .wdata       (good_wdata),
      .rden        (good_rden),
      .rdata       (good_rdata),
      .empty       (good_empty),
      .full        (),
      .afull       (good_afull)
   );

   ifm_sync_fifo #(
      .width        (ifm_pkg::ctrl_w),
      .depth_log2   (fifo_depth_log2),
      .afull_margin (afull_margin)
   ) i_ctrl_fifo (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .wren        (ctrl_wren),
      .wdata       (ctrl_wdata),
      .rden        (ctrl_rden),
      .rdata       (ctrl_rdata),
      .empty       (ctrl_empty),
      .full        (),
      .afull       (ctrl_afull)
   );

   ifm_out_fsm i_out_fsm (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .data_rdata  (data_rdata),
      .data_rden   (data_rden),
      .info_rdata  (info_rdata),
      .info_empty  (info_empty),
      .info_rden   (info_rden),
      .good_wdata  (good_wdata),
      .good_wren   (good_wren),
      .good_afull  (good_afull),
      .ctrl_wren   (ctrl_wren),
      .ctrl_afull  (ctrl_afull),
      .frame_clr   (frame_clr),
      .beat_wr     (beat_wr),
      .beat_keep   (beat_keep),
      .word_idx    (word_idx)
   );

   ifm_status_gen i_status_gen (
      .s2mm_clk    (s2mm_clk),
      .frame_clr   (frame_clr),
      .beat_wr     (beat_wr),
      .beat_keep   (beat_keep),
      .word_idx    (word_idx),
      .ctrl_wdata  (ctrl_wdata)
   );

endmodule

// File: ifm_rx_writer.sv
`timescale 1ns/10ps

module ifm_rx_writer (
   input  logic                        s2mm_clk,
   input  logic                        s2mm_resetn,

   // mac beat stream
   input  logic                        rx_valid,
   input  logic [ifm_pkg::data_w-1:0]  rx_data,
   input  logic [ifm_pkg::keep_w-1:0]  rx_keep,
   input  logic                        rx_last,
   input  logic                        rx_good,
   output logic                        rx_ready,

   // data fifo write side
   output logic                        data_wren,
   output logic [ifm_pkg::beat_w-1:0]  data_wdata,
   input  logic                        data_full,

   // info fifo write side, one verdict per frame
   output logic                        info_wren,
   output logic                        info_wdata,
   input  logic                        info_full
);

   // enable flop, low through reset and the first cycle after it
   logic ready_en;
   logic info_block;
   logic accept;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         ready_en <= 1'b0;
      end
      else
      begin
         ready_en <= 1'b1;
      end
   end

   // info fifo only matters when the offered beat closes the frame
   assign info_block = info_full && rx_last;

   assign rx_ready = ready_en && !data_full && !info_block;

   // beat moves when both sides agree
   assign accept = rx_valid && rx_ready;

   // every accepted beat goes to the data fifo
   assign data_wren = accept;

   // pack as {last, keep, data}
   assign data_wdata = {rx_last, rx_keep, rx_data};

   // verdict written on the same edge as the last beat,
   // so a non-empty info fifo means the whole frame is stored
   assign info_wren  = accept && rx_last;
   assign info_wdata = rx_good;

endmodule

// File: ifm_status_gen.sv
`timescale 1ns/10ps

module ifm_status_gen (
   input  logic                        s2mm_clk,

   // from the fsm
   input  logic                        frame_clr,
   input  logic                        beat_wr,
   input  logic [ifm_pkg::keep_w-1:0]  beat_keep,
   input  logic [2:0]                  word_idx,

   // control fifo write data, one cycle after word_idx
   output logic [ifm_pkg::ctrl_w-1:0]  ctrl_wdata
);

   localparam int nbytes_w = $clog2(ifm_pkg::keep_w + 1);

   logic [nbytes_w-1:0]           beat_bytes;
   logic [ifm_pkg::bytecnt_w-1:0] bytecnt;
   logic [31:0]                   payload;

   // contiguous low mask to byte count, anything else counts as 0
   function automatic logic [nbytes_w-1:0] keep_to_bytes(
      input logic [ifm_pkg::keep_w-1:0] keep
   );
      logic [nbytes_w-1:0] n;
      n = '0;
      for (int k = 1; k <= ifm_pkg::keep_w; k++)
      begin
         if (keep == ifm_pkg::keep_w'((1 << k) - 1))
            n = nbytes_w'(k);
      end
      return n;
   endfunction

   // per beat byte count, zero on idle cycles
   always_ff @(posedge s2mm_clk)
   begin
      beat_bytes <= beat_wr ? keep_to_bytes(beat_keep) : '0;
   end

   // frame length accumulator
   always_ff @(posedge s2mm_clk)
   begin
      if (frame_clr)
         bytecnt <= '0;
      else
         bytecnt <= bytecnt + ifm_pkg::bytecnt_w'(beat_bytes);
   end

   // status payload mux
   always_comb
   begin
      payload = '0;
      case (word_idx)
         3'd0:
            payload = ifm_pkg::stat_flags_word;
         3'd3:
            payload[ifm_pkg::stat_word3_bit] = 1'b1;
         3'd5:
            payload[ifm_pkg::bytecnt_w-1:0] = bytecnt;
         // words 1, 2, 4 carry mcast / vlan fields, fixed zero here
         default:
            payload = '0;
      endcase
   end

   always_ff @(posedge s2mm_clk)
   begin
      // last status word closes the frame
      ctrl_wdata[ifm_pkg::ctrl_last] <= (word_idx == 3'(ifm_pkg::status_words - 1));
      ctrl_wdata[35:32]              <= 4'hf;
      ctrl_wdata[31:0]               <= payload;
   end

endmodule

// File: ifm_sync_fifo.sv
`timescale 1ns/10ps

module ifm_sync_fifo #(
   parameter int width = 8,
   parameter int depth_log2 = 4,
   parameter int afull_margin = 2
) (
   input  logic             s2mm_clk,
   input  logic             s2mm_resetn,
   input  logic             wren,
   input  logic [width-1:0] wdata,
   input  logic             rden,
   output logic [width-1:0] rdata,
   output logic             empty,
   output logic             full,
   output logic             afull
);

   localparam int depth = 1 << depth_log2;

   // frame word storage
   logic [width-1:0] mem [depth];

   logic [depth_log2-1:0] wr_ptr;
   logic [depth_log2-1:0] rd_ptr;
   logic [depth_log2:0]   count;
   logic [depth_log2:0]   count_nxt;
   logic [depth_log2:0]   free_nxt;
   logic                  wr_ok;
   logic                  rd_ok;

   // overflow and underflow are dropped here
   assign wr_ok = wren && !full;
   assign rd_ok = rden && !empty;

   always_comb
   begin
      case ({wr_ok, rd_ok})
         2'b10:   count_nxt = count + 1'b1;
         2'b01:   count_nxt = count - 1'b1;
         default: count_nxt = count;
      endcase
      free_nxt = (depth_log2 + 1)'(depth) - count_nxt;
   end

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         afull  <= 1'b0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count_nxt;
         // registered from the next occupancy so it is exact
         afull <= int'(free_nxt) < afull_margin;
      end
   end

   always_ff @(posedge s2mm_clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wdata;
   end

   // show-ahead, head word visible while not empty
   assign rdata = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == (depth_log2 + 1)'(depth));

endmodule

// File: tb_ifm_rx.sv
`timescale 1ns/10ps

module tb_ifm_rx;

   localparam logic [31:0] seed_base = 32'hf8a3_1ebd;

   logic        s2mm_clk;
   logic        s2mm_resetn;
   logic        rx_valid;
   logic [63:0] rx_data;
   logic [7:0]  rx_keep;
   logic        rx_last;
   logic        rx_good;
   logic        rx_ready;
   logic        good_rden;
   logic [72:0] good_rdata;
   logic        good_empty;
   logic        ctrl_rden;
   logic [36:0] ctrl_rdata;
   logic        ctrl_empty;

   // case table from the data file
   int          case_good[$];
   int          case_len[$];
   int          case_off[$];
   // expected good beats and good frame lengths, in send order
   logic [72:0] exp_beats[$];
   int          exp_lens[$];
   int          n_good;
   int          total_beats;
   bit          cases_loaded;
   bit          bp_armed;
   bit          bp_seen;
   integer      rd_seed;

   ifm_rx_top i_ifm_rx_top (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .rx_keep     (rx_keep),
      .rx_last     (rx_last),
      .rx_good     (rx_good),
      .rx_ready    (rx_ready),
      .good_rden   (good_rden),
      .good_rdata  (good_rdata),
      .good_empty  (good_empty),
      .ctrl_rden   (ctrl_rden),
      .ctrl_rdata  (ctrl_rdata),
      .ctrl_empty  (ctrl_empty)
   );

   initial
   begin
      s2mm_clk = 1'b0;
   end

   // 20 ns period
   always #10 s2mm_clk = ~s2mm_clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [79:0] got,
                              input logic [79:0] expv);
      assert (got === expv)
      else
         abort_run($sformatf("ERR %s got %h exp %h", name, got, expv));
   endtask

   // low len mod 8 bytes on the last beat, all 8 when it divides
   function automatic logic [7:0] last_keep(input int len);
      int rem;
      rem = len % 8;
      if (rem == 0)
         return 8'hff;
      return 8'((1 << rem) - 1);
   endfunction

   // six status words per good frame
   function automatic logic [36:0] status_word(input int idx, input int len);
      logic [31:0] p;
      p = 32'h0;
      case (idx)
         0: p = 32'h5000_0000;
         3: p = 32'h0000_0040;
         5: p = 32'(len & 32'hffff);
         default: p = 32'h0;
      endcase
      return {(idx == 5), 4'hf, p};
   endfunction

   task automatic load_cases();
      int    fd;
      int    n;
      int    v;
      int    l;
      int    o;
      string line;
      fd = $fopen("ifm_rx_cases.txt", "r");
      assert (fd != 0)
      else
         abort_run("cannot open ifm_rx_cases.txt");
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         // skip comment and blank lines
         if (n > 0 && line.len() > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%d %d %h", v, l, o);
            if (n == 3)
            begin
               assert (l >= 1 && l <= 1500)
               else
                  abort_run("case file holds a frame length outside 1 to 1500");
               case_good.push_back(v);
               case_len.push_back(l);
               case_off.push_back(o);
               total_beats += (l + 7) / 8;
               if (v != 0)
                  n_good++;
            end
         end
      end
      $fclose(fd);
      assert (case_len.size() > 0)
      else
         abort_run("case file holds no frames");
   endtask

   // offer one beat, hold it until the handshake completes
   task automatic send_beat(input logic [63:0] d, input logic [7:0] k,
                            input logic lst, input logic g);
      bit taken;
      rx_valid = 1'b1;
      rx_data  = d;
      rx_keep  = k;
      rx_last  = lst;
      rx_good  = g;
      do
      begin
         // ready is settled by the falling edge
         @(negedge s2mm_clk);
         taken = rx_ready;
         @(posedge s2mm_clk);
         #2;
      end
      while (!taken);
   endtask

   task automatic send_frames();
      integer      seed;
      int          nb;
      logic [63:0] d;
      logic [7:0]  k;
      logic        lst;
      for (int f = 0; f < case_len.size(); f++)
      begin
         seed = seed_base + case_off[f];
         nb = (case_len[f] + 7) / 8;
         if (case_good[f] != 0)
            exp_lens.push_back(case_len[f]);
         for (int b = 0; b < nb; b++)
         begin
            d[63:32] = $random(seed);
            d[31:0]  = $random(seed);
            lst = (b == nb - 1);
            k = lst ? last_keep(case_len[f]) : 8'hff;
            // bad frames expect nothing downstream
            if (case_good[f] != 0)
               exp_beats.push_back({lst, k, d});
            send_beat(d, k, lst, case_good[f] != 0);
         end
      end
      rx_valid = 1'b0;
      rx_last  = 1'b0;
   endtask

   // short random reader pauses
   task automatic reader_stall();
      int s;
      s = $random(rd_seed) & 32'h1f;
      if (s < 6)
         repeat (s)
         begin
            @(posedge s2mm_clk);
            #2;
         end
   endtask

   task automatic pop_good(output logic [72:0] w);
      while (good_empty)
      begin
         @(posedge s2mm_clk);
         #2;
      end
      w = good_rdata;
      good_rden = 1'b1;
      @(posedge s2mm_clk);
      #2;
      good_rden = 1'b0;
   endtask

   task automatic pop_ctrl(output logic [36:0] w);
      while (ctrl_empty)
      begin
         @(posedge s2mm_clk);
         #2;
      end
      w = ctrl_rdata;
      ctrl_rden = 1'b1;
      @(posedge s2mm_clk);
      #2;
      ctrl_rden = 1'b0;
   endtask

   task automatic check_frames();
      logic [72:0] got;
      logic [72:0] expw;
      logic [36:0] cw;
      int          len;
      int          waited;
      for (int f = 0; f < n_good; f++)
      begin
         // long stall after the first frame, until the writer backs off
         if (f == 1)
         begin
            bp_armed = 1'b1;
            waited = 0;
            while (!bp_seen && waited < 4000)
            begin
               @(posedge s2mm_clk);
               #2;
               waited++;
            end
         end
         do
         begin
            reader_stall();
            pop_good(got);
            assert (exp_beats.size() > 0)
            else
               abort_run("good fifo returned a beat with no frame expected");
            expw = exp_beats.pop_front();
            check_value("good_rdata", got, expw);
         end
         while (!got[72]);
         assert (exp_lens.size() > 0)
         else
            abort_run("good frame finished with no length expected");
         len = exp_lens.pop_front();
         for (int w = 0; w < ifm_pkg::status_words; w++)
         begin
            reader_stall();
            pop_ctrl(cw);
            check_value("ctrl_rdata", cw, status_word(w, len));
         end
      end
   endtask

   // writer back-pressure while the reader sits idle
   always @(negedge s2mm_clk)
   begin
      if (bp_armed && rx_valid && !rx_ready)
         bp_seen = 1'b1;
   end

   // bound fsm checker status
   always @(negedge s2mm_clk)
   begin
      if (s2mm_resetn)
         assert (i_ifm_rx_top.i_out_fsm.i_fsm_assertions.err_count == 0)
         else
            abort_run("protocol assertion fired in the output fsm");
   end

   // limit scales with the beats in the case file
   initial
   begin
      wait (cases_loaded);
      repeat (total_beats * 8 + 2000) @(posedge s2mm_clk);
      abort_run("timeout, frames did not all come out in time");
   end

   initial
   begin
      rx_valid    = 1'b0;
      rx_data     = '0;
      rx_keep     = '0;
      rx_last     = 1'b0;
      rx_good     = 1'b0;
      good_rden   = 1'b0;
      ctrl_rden   = 1'b0;
      s2mm_resetn = 1'b0;
      bp_armed    = 1'b0;
      bp_seen     = 1'b0;
      n_good      = 0;
      total_beats = 0;
      rd_seed     = seed_base;
      load_cases();
      cases_loaded = 1'b1;
      repeat (8) @(posedge s2mm_clk);
      #2;
      s2mm_resetn = 1'b1;
      assert (good_empty && ctrl_empty)
      else
         abort_run("output fifos not empty after reset");
      // ready comes up one cycle after reset release
      assert (!rx_ready)
      else
         abort_run("rx_ready high in the first cycle after reset");
      fork
         send_frames();
         check_frames();
      join
      // let trailing bad frames drain
      repeat (300)
      begin
         @(posedge s2mm_clk);
         #2;
      end
      assert (good_empty && ctrl_empty)
      else
         abort_run("output fifos hold data after the last good frame");
      assert (exp_beats.size() == 0)
      else
         abort_run("expected good beats never came out");
      assert (bp_seen)
      else
         abort_run("rx_ready never dropped while the reader was stalled");
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: tb_ifm_rx_assertions.sv
`timescale 1ns/10ps

module tb_ifm_rx_assertions (
   input logic s2mm_clk,
   input logic s2mm_resetn,
   input logic data_rden,
   input logic info_rden,
   input logic info_good,
   input logic good_wren,
   input logic good_last,
   input logic good_afull,
   input logic ctrl_wren
);

   // failed property count
   int err_count = 0;

   // frame start seen with good fifo almost full, no copy may follow
   a_start_room: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      $rose(data_rden) && good_afull |=> !good_wren)
      else
      begin
         $error("good fifo written for a frame started while almost full");
         err_count++;
      end

   // status burst is exactly six words long
   a_six_words: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      $rose(ctrl_wren) |-> ctrl_wren [*6] ##1 !ctrl_wren)
      else
      begin
         $error("control fifo burst is not six words");
         err_count++;
      end

   // good verdict pop puts the frame's last beat into the good fifo next cycle
   a_info_last: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      info_rden && info_good |=> good_wren && good_last)
      else
      begin
         $error("info fifo popped without a last beat");
         err_count++;
      end

   // every last beat written had its verdict popped with it
   a_last_info: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      good_wren && good_last |-> $past(info_rden))
      else
      begin
         $error("last beat written without an info fifo pop");
         err_count++;
      end

endmodule

bind ifm_out_fsm tb_ifm_rx_assertions i_fsm_assertions (
   .s2mm_clk    (s2mm_clk),
   .s2mm_resetn (s2mm_resetn),
   .data_rden   (data_rden),
   .info_rden   (info_rden),
   .info_good   (info_rdata),
   .good_wren   (good_wren),
   .good_last   (good_wdata[ifm_pkg::beat_last]),
   .good_afull  (good_afull),
   .ctrl_wren   (ctrl_wren)
);
